// File: lane_pkg.sv
package lane_pkg;

  // Register file geometry
  localparam int unsigned VREG_WORDS = 4;
  localparam int unsigned NUM_VREGS  = 32;

  // One 64-bit slice of a vector register
  typedef logic [63:0] word_t;
  // Vector register number
  typedef logic [$clog2(NUM_VREGS)-1:0] vreg_t;
  // Word index inside one register
  typedef logic [$clog2(VREG_WORDS)-1:0] widx_t;
  // Operation length in words, 1 to VREG_WORDS
  typedef logic [2:0] vlen_t;
  // Bank address, register number above word index
  typedef logic [$bits(vreg_t)+$bits(widx_t)-1:0] vaddr_t;
  // Operation tag
  typedef logic [2:0] op_id_t;

  // One done bit per possible id
  localparam int unsigned NUM_IDS = 2 ** $bits(op_id_t);

  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VSLL,
    VSRL,
    VMIN,
    VMAX
  } alu_op_e;

  // Element width, 8 << code bits
  typedef enum logic [1:0] {
    E8,
    E16,
    E32,
    E64
  } ewidth_e;

  typedef struct packed {
    alu_op_e op;
    ewidth_e width;
    logic    signed_op;
    logic    masked;
    logic    use_imm;
    word_t   imm;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    vlen_t   length;
    op_id_t  id;
  } operation_t;

  // Commit side of the ALU unit
  typedef enum logic {
    IDLE,
    COMMIT
  } commit_state_e;

endpackage

// File: lane_ifs.sv
// Issue-head operation as seen by the fetcher
interface issue_if;
  logic              valid;
  lane_pkg::vreg_t   vs1;
  lane_pkg::vreg_t   vs2;
  logic              masked;
  lane_pkg::vlen_t   length;

  modport alu (output valid, vs1, vs2, masked, length);
  modport fetch (input valid, vs1, vs2, masked, length);
endinterface

// One fetched operand set
interface operand_if;
  logic            valid;
  logic            ready;
  lane_pkg::word_t a;
  lane_pkg::word_t b;
  // All ones when unmasked
  lane_pkg::word_t m;
  // Last word of the operation
  logic            last;

  modport source (output valid, a, b, m, last, input ready);
  modport sink (input valid, a, b, m, last, output ready);
endinterface

// Write-back request towards the bank
interface wb_if;
  logic               req;
  logic               gnt;
  lane_pkg::vaddr_t   addr;
  lane_pkg::word_t    wdata;
  lane_pkg::op_id_t   id;

  modport alu (output req, addr, wdata, id, input gnt);
  modport bank (input req, addr, wdata, id, output gnt);
endinterface

// File: vrf_bank.sv
module vrf_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Operand read ports
  input  lane_pkg::vaddr_t [2:0] rd_addr_i,
  output lane_pkg::word_t  [2:0] rd_data_o,
  // Host port
  input  logic                   host_we_i,
  input  lane_pkg::vaddr_t       host_addr_i,
  input  lane_pkg::word_t        host_wdata_i,
  output lane_pkg::word_t        host_rdata_o,
  // Write-back from the ALU unit
  wb_if.bank                     wb
);

  localparam int unsigned NUM_WORDS = lane_pkg::NUM_VREGS * lane_pkg::VREG_WORDS;

  lane_pkg::word_t mem_q [NUM_WORDS];

  // Host takes the single write port
  // ALU write-back only gets it in host-idle cycles
  assign wb.gnt = wb.req && !host_we_i;

  always_ff @(posedge clk_i) begin
    if (host_we_i) begin
      mem_q[host_addr_i] <= host_wdata_i;
    end else if (wb.gnt) begin
      mem_q[wb.addr] <= wb.wdata;
    end
  end

  // Registered reads, old data on a same-cycle write
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 3; i++) begin
      rd_data_o[i] <= mem_q[rd_addr_i[i]];
    end
    host_rdata_o <= mem_q[host_addr_i];
  end

  // Stalled request is held by the ALU unit until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb.req && !wb.gnt |=> wb.req && $stable(wb.addr) && $stable(wb.wdata));

endmodule

// File: operand_fetch.sv
module operand_fetch (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Issue-head operation
  issue_if.fetch                 issue,
  // Bank read ports, data one cycle after address
  output lane_pkg::vaddr_t [2:0] rd_addr_o,
  input  lane_pkg::word_t  [2:0] rd_data_i,
  // Operand sets towards the ALU unit
  operand_if.source              opnd
);

  // Read side
  lane_pkg::widx_t widx_q;
  logic            fetch_done_q;
  logic            rd_pend_q;
  logic            pend_last_q;

  // Operand register and skid slot, index 0 a, 1 b, 2 m
  logic                  opnd_valid_q;
  lane_pkg::word_t [2:0] opnd_q;
  logic                  opnd_last_q;
  logic                  skid_valid_q;
  lane_pkg::word_t [2:0] skid_q;
  logic                  skid_last_q;

  logic                  xfer;
  logic                  reg_free;
  logic                  last_word;
  logic                  rd_issue;
  logic [1:0]            occupancy;
  lane_pkg::word_t [2:0] landing;

  assign rd_addr_o[0] = {issue.vs1, widx_q};
  assign rd_addr_o[1] = {issue.vs2, widx_q};
  // Mask always comes from v0
  assign rd_addr_o[2] = {lane_pkg::vreg_t'(0), widx_q};

  assign last_word = lane_pkg::vlen_t'(widx_q) == issue.length - lane_pkg::vlen_t'(1);
  assign xfer      = opnd_valid_q && opnd.ready;
  assign reg_free  = !opnd_valid_q || xfer;

  // Sets held or in flight once this cycle's transfer is gone
  assign occupancy = 2'(opnd_valid_q) + 2'(skid_valid_q) + 2'(rd_pend_q) - 2'(xfer);
  // Never more reads out than the two slots can catch
  assign rd_issue  = issue.valid && !fetch_done_q && (occupancy < 2'd2);

  assign landing[0] = rd_data_i[0];
  assign landing[1] = rd_data_i[1];
  assign landing[2] = issue.masked ? rd_data_i[2] : '1;

  assign opnd.valid = opnd_valid_q;
  assign opnd.a     = opnd_q[0];
  assign opnd.b     = opnd_q[1];
  assign opnd.m     = opnd_q[2];
  assign opnd.last  = opnd_last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      widx_q       <= '0;
      fetch_done_q <= 1'b0;
      rd_pend_q    <= 1'b0;
      pend_last_q  <= 1'b0;
      opnd_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      rd_pend_q <= rd_issue;
      if (rd_issue) begin
        pend_last_q <= last_word;
        widx_q      <= last_word ? '0 : widx_q + lane_pkg::widx_t'(1);
        // Wait here until the head is popped
        if (last_word) begin
          fetch_done_q <= 1'b1;
        end
      end
      // Head pops with its last set, next op starts
      if (xfer && opnd_last_q) begin
        fetch_done_q <= 1'b0;
      end
      // Skid drains first to keep word order
      if (reg_free) begin
        opnd_valid_q <= skid_valid_q || rd_pend_q;
        skid_valid_q <= skid_valid_q && rd_pend_q;
      end else if (rd_pend_q) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_free && skid_valid_q) begin
      opnd_q      <= skid_q;
      opnd_last_q <= skid_last_q;
    end else if (reg_free && rd_pend_q) begin
      opnd_q      <= landing;
      opnd_last_q <= pend_last_q;
    end
    // Landing data parks in the skid slot
    if (rd_pend_q && (!reg_free || skid_valid_q)) begin
      skid_q      <= landing;
      skid_last_q <= pend_last_q;
    end
  end

  // Offered set stays put until the ALU unit takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    opnd.valid && !opnd.ready |=> opnd.valid && $stable(opnd.a) && $stable(opnd.last));

endmodule

// File: simd_alu.sv
module simd_alu (
  input  lane_pkg::alu_op_e op_i,
  input  lane_pkg::ewidth_e width_i,
  input  logic              signed_i,
  input  lane_pkg::word_t   operand_a_i,
  input  lane_pkg::word_t   operand_b_i,
  input  lane_pkg::word_t   operand_m_i,
  output lane_pkg::word_t   result_o
);

  // One element, zero-extended into a word, ew bits wide
  function automatic lane_pkg::word_t elem_op(
    input lane_pkg::alu_op_e op,
    input logic              sgn,
    input lane_pkg::word_t   a,
    input lane_pkg::word_t   b,
    input logic              en,
    input int unsigned       ew
  );
    lane_pkg::word_t keep;
    lane_pkg::word_t flip;
    lane_pkg::word_t res;
    logic [5:0]      shamt;
    logic            a_lt_b;
    keep   = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    // Sign bit flipped turns the signed compare into an unsigned one
    flip   = sgn ? (64'd1 << (ew - 1)) : '0;
    // Low log2(ew) bits of b
    shamt  = b[5:0] & 6'(ew - 1);
    a_lt_b = (a ^ flip) < (b ^ flip);
    unique case (op)
      lane_pkg::VADD: res = a + b;
      lane_pkg::VSUB: res = a - b;
      lane_pkg::VAND: res = a & b;
      lane_pkg::VOR:  res = a | b;
      lane_pkg::VXOR: res = a ^ b;
      lane_pkg::VSLL: res = a << shamt;
      // Logical since a is zero-extended
      lane_pkg::VSRL: res = a >> shamt;
      lane_pkg::VMIN: res = a_lt_b ? a : b;
      lane_pkg::VMAX: res = a_lt_b ? b : a;
      default:        res = '0;
    endcase
    // Masked-off element reads zero
    return en ? (res & keep) : '0;
  endfunction

  // Result word per element width
  lane_pkg::word_t res_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    for (genvar i = 0; i < 64 / EW; i++) begin : g_elem
      lane_pkg::word_t full;
      // Mask field's lowest bit enables the element
      assign full = elem_op(op_i, signed_i,
                            64'(operand_a_i[EW*i +: EW]),
                            64'(operand_b_i[EW*i +: EW]),
                            operand_m_i[EW*i], EW);
      assign res_w[w][EW*i +: EW] = full[EW-1:0];
    end
  end

  assign result_o = res_w[width_i];

endmodule

// File: valu.sv
module valu #(
  parameter int unsigned OPQ_DEPTH  = 4,
  parameter int unsigned OBUF_DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // New operations
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  lane_pkg::operation_t         operation_i,
  // Fetch side
  issue_if.alu                         issue,
  operand_if.sink                      opnd,
  // Write-back side
  wb_if.alu                            wb,
  output logic [lane_pkg::NUM_IDS-1:0] done_o
);

  localparam int unsigned QPW = $clog2(OPQ_DEPTH);
  localparam int unsigned BPW = (OBUF_DEPTH > 1) ? $clog2(OBUF_DEPTH) : 1;

  // Operation queue
  lane_pkg::operation_t opq_q [OPQ_DEPTH];
  logic [QPW-1:0]       accept_ptr_q;
  logic [QPW-1:0]       issue_ptr_q;
  logic [QPW-1:0]       commit_ptr_q;
  // Ops not fully fetched, ops not fully written
  logic [QPW:0]         issue_cnt_q;
  logic [QPW:0]         commit_cnt_q;
  lane_pkg::operation_t issue_op;
  lane_pkg::operation_t commit_op;

  // Output buffer
  lane_pkg::word_t obuf_q [OBUF_DEPTH];
  logic [BPW-1:0]  obuf_wr_q;
  logic [BPW-1:0]  obuf_rd_q;
  logic [BPW:0]    obuf_cnt_q;

  // Commit side
  lane_pkg::commit_state_e state_q;
  lane_pkg::commit_state_e state_d;
  lane_pkg::widx_t         commit_widx_q;

  logic            accept;
  logic            opnd_xfer;
  logic            issue_pop;
  logic            wb_fire;
  logic            commit_pop;
  lane_pkg::word_t operand_b;
  lane_pkg::word_t alu_result;

  assign issue_op  = opq_q[issue_ptr_q];
  assign commit_op = opq_q[commit_ptr_q];

  assign op_ready_o = commit_cnt_q != (QPW+1)'(OPQ_DEPTH);
  assign accept     = op_valid_i && op_ready_o;

  assign issue.valid  = issue_cnt_q != '0;
  assign issue.vs1    = issue_op.vs1;
  assign issue.vs2    = issue_op.vs2;
  assign issue.masked = issue_op.masked;
  assign issue.length = issue_op.length;

  // Stop taking operands once the buffer is full
  assign opnd.ready = obuf_cnt_q != (BPW+1)'(OBUF_DEPTH);
  assign opnd_xfer  = opnd.valid && opnd.ready;
  assign issue_pop  = opnd_xfer && opnd.last;

  // Immediate replaces vs2 in every word
  assign operand_b = issue_op.use_imm ? issue_op.imm : opnd.b;

  simd_alu i_simd_alu (
    .op_i        (issue_op.op),
    .width_i     (issue_op.width),
    .signed_i    (issue_op.signed_op),
    .operand_a_i (opnd.a),
    .operand_b_i (operand_b),
    .operand_m_i (opnd.m),
    .result_o    (alu_result)
  );

  assign wb.req   = obuf_cnt_q != '0;
  assign wb.addr  = {commit_op.vd, commit_widx_q};
  assign wb.wdata = obuf_q[obuf_rd_q];
  assign wb.id    = commit_op.id;

  assign wb_fire    = wb.gnt && (state_q == lane_pkg::COMMIT);
  assign commit_pop = wb_fire &&
                      (lane_pkg::vlen_t'(commit_widx_q) == commit_op.length - lane_pkg::vlen_t'(1));
  // Pulse in the cycle the last word is written
  assign done_o     = commit_pop ? (lane_pkg::NUM_IDS'(1) << wb.id) : '0;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lane_pkg::IDLE: begin
        if (commit_cnt_q != '0) begin
          state_d = lane_pkg::COMMIT;
        end
      end
      lane_pkg::COMMIT: begin
        // Last op leaves and nothing new arrives
        if (commit_pop && commit_cnt_q == (QPW+1)'(1) && !accept) begin
          state_d = lane_pkg::IDLE;
        end
      end
      default: state_d = lane_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q  <= '0;
      issue_ptr_q   <= '0;
      commit_ptr_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      obuf_wr_q     <= '0;
      obuf_rd_q     <= '0;
      obuf_cnt_q    <= '0;
      state_q       <= lane_pkg::IDLE;
      commit_widx_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        accept_ptr_q <= accept_ptr_q + QPW'(1);
      end
      if (issue_pop) begin
        issue_ptr_q <= issue_ptr_q + QPW'(1);
      end
      if (commit_pop) begin
        commit_ptr_q <= commit_ptr_q + QPW'(1);
      end
      issue_cnt_q  <= issue_cnt_q + (QPW+1)'(accept) - (QPW+1)'(issue_pop);
      commit_cnt_q <= commit_cnt_q + (QPW+1)'(accept) - (QPW+1)'(commit_pop);
      // Circular buffer, depth need not be a power of two
      if (opnd_xfer) begin
        obuf_wr_q <= (obuf_wr_q == BPW'(OBUF_DEPTH - 1)) ? '0 : obuf_wr_q + BPW'(1);
      end
      if (wb_fire) begin
        obuf_rd_q <= (obuf_rd_q == BPW'(OBUF_DEPTH - 1)) ? '0 : obuf_rd_q + BPW'(1);
      end
      obuf_cnt_q <= obuf_cnt_q + (BPW+1)'(opnd_xfer) - (BPW+1)'(wb_fire);
      // Word address restarts at vd word 0 for each op
      if (state_q == lane_pkg::IDLE || commit_pop) begin
        commit_widx_q <= '0;
      end else if (wb_fire) begin
        commit_widx_q <= commit_widx_q + lane_pkg::widx_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      opq_q[accept_ptr_q] <= operation_i;
    end
    if (opnd_xfer) begin
      obuf_q[obuf_wr_q] <= alu_result;
    end
  end

  // Queue bound, and fetch never runs ahead of commit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_cnt_q <= (QPW+1)'(OPQ_DEPTH) && issue_cnt_q <= commit_cnt_q);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    obuf_cnt_q <= (BPW+1)'(OBUF_DEPTH));

  // Buffered results always have an op in commit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb.req |-> state_q == lane_pkg::COMMIT);

endmodule

// File: alu_lane.sv
module alu_lane #(
  parameter int unsigned OPQ_DEPTH  = 4,
  parameter int unsigned OBUF_DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Operation queue entry
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  lane_pkg::alu_op_e            op_code_i,
  input  lane_pkg::ewidth_e            op_width_i,
  input  logic                         op_signed_i,
  input  logic                         op_masked_i,
  input  logic                         op_use_imm_i,
  input  lane_pkg::word_t              op_imm_i,
  input  lane_pkg::vreg_t              op_vs1_i,
  input  lane_pkg::vreg_t              op_vs2_i,
  input  lane_pkg::vreg_t              op_vd_i,
  input  lane_pkg::vlen_t              op_len_i,
  input  lane_pkg::op_id_t             op_id_i,
  // Completion pulses per id
  output logic [lane_pkg::NUM_IDS-1:0] done_o,
  // Host access to the bank
  input  logic                         host_we_i,
  input  lane_pkg::vaddr_t             host_addr_i,
  input  lane_pkg::word_t              host_wdata_i,
  output lane_pkg::word_t              host_rdata_o
);

  lane_pkg::operation_t   operation;
  lane_pkg::vaddr_t [2:0] rd_addr;
  lane_pkg::word_t  [2:0] rd_data;

  issue_if   issue ();
  operand_if opnd ();
  wb_if      wb ();

  // Plain ports packed into one queue entry
  assign operation = '{
    op:        op_code_i,
    width:     op_width_i,
    signed_op: op_signed_i,
    masked:    op_masked_i,
    use_imm:   op_use_imm_i,
    imm:       op_imm_i,
    vs1:       op_vs1_i,
    vs2:       op_vs2_i,
    vd:        op_vd_i,
    length:    op_len_i,
    id:        op_id_i
  };

  vrf_bank i_vrf_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o),
    .wb           (wb.bank)
  );

  operand_fetch i_operand_fetch (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .issue     (issue.fetch),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data),
    .opnd      (opnd.source)
  );

  valu #(
    .OPQ_DEPTH  (OPQ_DEPTH),
    .OBUF_DEPTH (OBUF_DEPTH)
  ) i_valu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_valid_i  (op_valid_i),
    .op_ready_o  (op_ready_o),
    .operation_i (operation),
    .issue       (issue.alu),
    .opnd        (opnd.sink),
    .wb          (wb.alu),
    .done_o      (done_o)
  );

endmodule

// File: tb_alu_lane.sv
module tb_alu_lane;
  timeunit 1ns;
  timeprecision 100ps;

  // Op count of all tests, sets the cycle limit
  localparam int unsigned NUM_OPS        = 96;
  localparam int unsigned TIMEOUT_CYCLES = 40 * NUM_OPS + 200;
  localparam int unsigned NUM_WORDS      = lane_pkg::NUM_VREGS * lane_pkg::VREG_WORDS;

  typedef logic [lane_pkg::NUM_IDS-1:0] done_t;
  // All words of one vector register
  typedef lane_pkg::word_t [lane_pkg::VREG_WORDS-1:0] vreg_val_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 op_valid_i;
  logic                 op_ready_o;
  lane_pkg::alu_op_e    op_code_i;
  lane_pkg::ewidth_e    op_width_i;
  logic                 op_signed_i;
  logic                 op_masked_i;
  logic                 op_use_imm_i;
  lane_pkg::word_t      op_imm_i;
  lane_pkg::vreg_t      op_vs1_i;
  lane_pkg::vreg_t      op_vs2_i;
  lane_pkg::vreg_t      op_vd_i;
  lane_pkg::vlen_t      op_len_i;
  lane_pkg::op_id_t     op_id_i;
  done_t                done_o;
  logic                 host_we_i;
  lane_pkg::vaddr_t     host_addr_i;
  lane_pkg::word_t      host_wdata_i;
  lane_pkg::word_t      host_rdata_o;

  // Shadow bank and outstanding ops, oldest first
  lane_pkg::word_t  shadow [NUM_WORDS];
  lane_pkg::op_id_t pend_id [$];
  lane_pkg::vreg_t  pend_vd [$];
  vreg_val_t        pend_res [$];

  string       cur_test;
  int          test_err;
  int          pass_cnt;
  int          fail_cnt;
  int unsigned cycle_cnt;
  logic        issue_done;

  alu_lane dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_valid_i   (op_valid_i),
    .op_ready_o   (op_ready_o),
    .op_code_i    (op_code_i),
    .op_width_i   (op_width_i),
    .op_signed_i  (op_signed_i),
    .op_masked_i  (op_masked_i),
    .op_use_imm_i (op_use_imm_i),
    .op_imm_i     (op_imm_i),
    .op_vs1_i     (op_vs1_i),
    .op_vs2_i     (op_vs2_i),
    .op_vd_i      (op_vd_i),
    .op_len_i     (op_len_i),
    .op_id_i      (op_id_i),
    .done_o       (done_o),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic lane_pkg::vaddr_t addr_of(input lane_pkg::vreg_t r, input int unsigned w);
    return {r, lane_pkg::widx_t'(w)};
  endfunction

  // Expected word, element by element
  function automatic lane_pkg::word_t alu_ref(
    input lane_pkg::alu_op_e op,
    input lane_pkg::ewidth_e width,
    input logic              sgn,
    input lane_pkg::word_t   a,
    input lane_pkg::word_t   b,
    input lane_pkg::word_t   m
  );
    int unsigned     ew;
    lane_pkg::word_t emask;
    lane_pkg::word_t ea;
    lane_pkg::word_t eb;
    lane_pkg::word_t er;
    lane_pkg::word_t res;
    longint          sa;
    longint          sb;
    logic            lt;
    ew    = 8 << int'(width);
    emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    res   = '0;
    for (int i = 0; i < 64 / ew; i++) begin
      ea = (a >> (i * ew)) & emask;
      eb = (b >> (i * ew)) & emask;
      // Sign-extended copies for signed min/max
      sa = $signed(ea << (64 - ew)) >>> (64 - ew);
      sb = $signed(eb << (64 - ew)) >>> (64 - ew);
      lt = sgn ? (sa < sb) : (ea < eb);
      case (op)
        lane_pkg::VADD: er = ea + eb;
        lane_pkg::VSUB: er = ea - eb;
        lane_pkg::VAND: er = ea & eb;
        lane_pkg::VOR:  er = ea | eb;
        lane_pkg::VXOR: er = ea ^ eb;
        // Shift amount is b modulo the element width
        lane_pkg::VSLL: er = ea << (eb % ew);
        lane_pkg::VSRL: er = ea >> (eb % ew);
        lane_pkg::VMIN: er = lt ? ea : eb;
        lane_pkg::VMAX: er = lt ? eb : ea;
        default:        er = '0;
      endcase
      // Lowest bit of the v0 field enables the element
      if (!m[i * ew]) begin
        er = '0;
      end
      res = res | ((er & emask) << (i * ew));
    end
    return res;
  endfunction

  task automatic check_word(input string what, input lane_pkg::word_t exp_w,
                            input lane_pkg::word_t act_w);
    if (act_w !== exp_w) begin
      $display("[ERROR] %s %s expected %h actual %h", cur_test, what, exp_w, act_w);
      test_err++;
    end
  endtask

  task automatic check_done(input string what, input done_t exp_d, input done_t act_d);
    if (act_d !== exp_d) begin
      $display("[ERROR] %s %s expected %b actual %b", cur_test, what, exp_d, act_d);
      test_err++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    if (test_err == 0) begin
      pass_cnt++;
      $display("%s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("%s: %0d errors", cur_test, test_err);
    end
  endtask

  // Host write, held for the next call or a release
  task automatic write_word(input lane_pkg::vaddr_t a, input lane_pkg::word_t d);
    @(posedge clk_i);
    host_we_i    <= 1'b1;
    host_addr_i  <= a;
    host_wdata_i <= d;
    shadow[a] = d;
  endtask

  task automatic host_release();
    @(posedge clk_i);
    host_we_i <= 1'b0;
  endtask

  task automatic load_random(input lane_pkg::vreg_t r);
    for (int w = 0; w < lane_pkg::VREG_WORDS; w++) begin
      write_word(addr_of(r, w), {$urandom, $urandom});
    end
  endtask

  // Read data lands one cycle after the address
  task automatic check_reg(input lane_pkg::vreg_t r, input string tag);
    lane_pkg::vaddr_t a;
    for (int w = 0; w < lane_pkg::VREG_WORDS; w++) begin
      a = addr_of(r, w);
      @(posedge clk_i);
      host_addr_i <= a;
      @(posedge clk_i);
      @(negedge clk_i);
      check_word($sformatf("%s v%0d[%0d]", tag, r, w), shadow[a], host_rdata_o);
    end
  endtask

  task automatic issue_op(
    input lane_pkg::alu_op_e op,
    input lane_pkg::ewidth_e width,
    input logic              sgn,
    input logic              masked,
    input logic              use_imm,
    input lane_pkg::word_t   imm,
    input lane_pkg::vreg_t   vs1,
    input lane_pkg::vreg_t   vs2,
    input lane_pkg::vreg_t   vd,
    input lane_pkg::vlen_t   len,
    input lane_pkg::op_id_t  id
  );
    vreg_val_t       res;
    lane_pkg::word_t a;
    lane_pkg::word_t b;
    lane_pkg::word_t m;
    for (int i = 0; i < lane_pkg::VREG_WORDS; i++) begin
      a = shadow[addr_of(vs1, i)];
      b = use_imm ? imm : shadow[addr_of(vs2, i)];
      m = masked ? shadow[addr_of(lane_pkg::vreg_t'(0), i)] : '1;
      // Words past the length keep their old value
      res[i] = (i < int'(len)) ? alu_ref(op, width, sgn, a, b, m) : shadow[addr_of(vd, i)];
    end
    pend_id.push_back(id);
    pend_vd.push_back(vd);
    pend_res.push_back(res);
    @(posedge clk_i);
    op_valid_i   <= 1'b1;
    op_code_i    <= op;
    op_width_i   <= width;
    op_signed_i  <= sgn;
    op_masked_i  <= masked;
    op_use_imm_i <= use_imm;
    op_imm_i     <= imm;
    op_vs1_i     <= vs1;
    op_vs2_i     <= vs2;
    op_vd_i      <= vd;
    op_len_i     <= len;
    op_id_i      <= id;
    // Taken on the next rising edge once ready is seen
    do @(negedge clk_i); while (!op_ready_o);
  endtask

  task automatic op_idle();
    @(posedge clk_i);
    op_valid_i <= 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (pend_id.size() != 0 && n < 200) begin
      @(posedge clk_i);
      n++;
    end
    if (pend_id.size() != 0) begin
      $display("%s: no done pulse for id %0d", cur_test, pend_id[0]);
      test_err++;
      pend_id.delete();
      pend_vd.delete();
      pend_res.delete();
    end
  endtask

  // Done pulses in issue order, shadow takes the result
  always @(negedge clk_i) begin
    if (rst_ni && done_o != '0) begin
      if (pend_id.size() == 0) begin
        $display("%s: done pulse %b with no operation outstanding", cur_test, done_o);
        test_err++;
      end else begin
        check_done($sformatf("done id %0d", pend_id[0]), done_t'(1) << pend_id[0], done_o);
        for (int w = 0; w < lane_pkg::VREG_WORDS; w++) begin
          shadow[addr_of(pend_vd[0], w)] = pend_res[0][w];
        end
        void'(pend_id.pop_front());
        void'(pend_vd.pop_front());
        void'(pend_res.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped at the limit of %0d cycles in %s", TIMEOUT_CYCLES, cur_test);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic run_opcodes();
    lane_pkg::alu_op_e op;
    int                n;
    n = 0;
    for (int k = 0; k < 9; k++) begin
      op = lane_pkg::alu_op_e'(k);
      start_test({"opcode ", op.name()});
      load_random(lane_pkg::vreg_t'(1));
      load_random(lane_pkg::vreg_t'(2));
      host_release();
      for (int w = 0; w < 4; w++) begin
        for (int s = 0; s < 2; s++) begin
          issue_op(op, lane_pkg::ewidth_e'(w), s[0], 1'b0, 1'b0, '0, 1, 2, 3, 4,
                   lane_pkg::op_id_t'(n));
          op_idle();
          wait_done();
          check_reg(3, $sformatf("E%0d sgn%0d", 8 << w, s));
          n++;
        end
      end
      end_test();
    end
  endtask

  task automatic run_mask_imm();
    logic masked;
    start_test("mask and immediate");
    load_random(lane_pkg::vreg_t'(0));
    host_release();
    for (int i = 0; i < 8; i++) begin
      masked = (i < 4) || (i == 7);
      issue_op(lane_pkg::alu_op_e'($urandom % 9), lane_pkg::ewidth_e'($urandom % 4),
               1'($urandom), masked, i >= 4, {$urandom, $urandom}, 1, 2, 3, 4,
               lane_pkg::op_id_t'(i));
      op_idle();
      wait_done();
      check_reg(3, $sformatf("op %0d", i));
    end
    end_test();
  endtask

  task automatic run_lengths();
    start_test("lengths");
    for (int len = 1; len <= 4; len++) begin
      issue_op(lane_pkg::alu_op_e'($urandom % 9), lane_pkg::E32, 1'b0, 1'b0, 1'b0, '0,
               1, 2, lane_pkg::vreg_t'(3 + len), lane_pkg::vlen_t'(len),
               lane_pkg::op_id_t'(len));
      op_idle();
      wait_done();
      check_reg(lane_pkg::vreg_t'(3 + len), $sformatf("len %0d", len));
    end
    end_test();
  endtask

  task automatic run_back_to_back();
    start_test("back to back");
    for (int i = 0; i < 4; i++) begin
      issue_op(lane_pkg::alu_op_e'($urandom % 9), lane_pkg::ewidth_e'($urandom % 4),
               1'($urandom), 1'($urandom), 1'b0, '0, 1, 2, lane_pkg::vreg_t'(8 + i),
               lane_pkg::vlen_t'(2 + $urandom % 3), lane_pkg::op_id_t'(4 + i));
    end
    op_idle();
    // Four ops queued and none retired yet
    @(negedge clk_i);
    if (op_ready_o) begin
      $display("%s: op_ready_o stayed high with a full queue", cur_test);
      test_err++;
    end
    wait_done();
    for (int i = 0; i < 4; i++) begin
      check_reg(lane_pkg::vreg_t'(8 + i), "result");
    end
    end_test();
  endtask

  task automatic run_backpressure();
    start_test("host back-pressure");
    issue_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          issue_op(lane_pkg::alu_op_e'($urandom % 9), lane_pkg::ewidth_e'($urandom % 4),
                   1'($urandom), 1'b0, 1'b0, '0, 1, 2, lane_pkg::vreg_t'(12 + i % 4), 4,
                   lane_pkg::op_id_t'(i));
        end
        op_idle();
        issue_done = 1'b1;
      end
      // Host writes to v16 and up steal the write port
      begin
        while (!issue_done || pend_id.size() != 0) begin
          if ($urandom % 2 == 0) begin
            write_word(addr_of(lane_pkg::vreg_t'(16 + $urandom % 16), $urandom % 4),
                       {$urandom, $urandom});
          end else begin
            host_release();
          end
        end
        host_release();
      end
    join
    wait_done();
    for (int i = 0; i < 4; i++) begin
      check_reg(lane_pkg::vreg_t'(12 + i), "result");
    end
    end_test();
  endtask

  initial begin
    void'($urandom(38));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    op_valid_i   = 1'b0;
    op_code_i    = lane_pkg::VADD;
    op_width_i   = lane_pkg::E8;
    op_signed_i  = 1'b0;
    op_masked_i  = 1'b0;
    op_use_imm_i = 1'b0;
    op_imm_i     = '0;
    op_vs1_i     = '0;
    op_vs2_i     = '0;
    op_vd_i      = '0;
    op_len_i     = 3'd1;
    op_id_i      = '0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    cycle_cnt    = 0;
    issue_done   = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    start_test("reset state");
    @(negedge clk_i);
    check_done("done_o", '0, done_o);
    if (!op_ready_o) begin
      $display("%s: op_ready_o low with an empty queue", cur_test);
      test_err++;
    end
    end_test();
    // Mask, sources and all result registers start known
    for (int r = 0; r < 16; r++) begin
      load_random(lane_pkg::vreg_t'(r));
    end
    host_release();
    run_opcodes();
    run_mask_imm();
    run_lengths();
    run_back_to_back();
    run_backpressure();
    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: alu_lane.f
lane_pkg.sv
lane_ifs.sv
vrf_bank.sv
operand_fetch.sv
simd_alu.sv
valu.sv
alu_lane.sv
tb_alu_lane.sv

// File: run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_lane \
  -f alu_lane.f --Mdir obj_dir -o sim_alu_lane > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_alu_lane > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
